// ==== Makefile ====
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_unit
FILELIST  ?= issue_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG) || \
		(echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dispatch_regs.sv ====
/*
 * Operand forwarding from the ROB and the registered dispatch outputs.
 * Station and ROB outputs follow the accept edge by one cycle, one cycle wide.
 * Only the target station's payload is loaded; the other holds its old value.
 */
`timescale 1ns/1ps
`include "issue_config.svh"

module dispatch_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_accept,
    input  issue_pkg::unit_e                   i_unit,
    input  issue_pkg::alu_op_e                 i_alu_op,
    input  issue_pkg::cmp_op_e                 i_cmp_op,
    input  logic                               i_is_br,
    input  logic                               i_use_rs2,
    input  logic                               i_use_pc,
    input  logic                               i_zero_rs1,
    input  logic [`XLEN-1:0]                   i_imm,
    input  logic [`XLEN-1:0]                   i_pc,
    input  logic                               i_br_pred,
    input  logic [`REG_W-1:0]                  i_rd,
    input  logic [`TAG_W-1:0]                  i_tag,
    input  logic [`TAG_W-1:0]                  i_reg_qj,
    input  logic [`TAG_W-1:0]                  i_reg_qk,
    input  logic [`XLEN-1:0]                   i_reg_vj,
    input  logic [`XLEN-1:0]                   i_reg_vk,
    input  logic [`ROB_DEPTH-1:0]              i_rob_ready,
    input  logic [`ROB_DEPTH-1:0][`XLEN-1:0]   i_rob_vals,
    output logic                               o_alu_valid,
    output logic [`XLEN-1:0]                   o_alu_vj,
    output logic [`XLEN-1:0]                   o_alu_vk,
    output logic [`TAG_W-1:0]                  o_alu_qj,
    output logic [`TAG_W-1:0]                  o_alu_qk,
    output issue_pkg::alu_op_e                 o_alu_op,
    output logic [`TAG_W-1:0]                  o_alu_dest,
    output logic                               o_cmp_valid,
    output logic                               o_cmp_is_br,
    output logic [`XLEN-1:0]                   o_cmp_vj,
    output logic [`XLEN-1:0]                   o_cmp_vk,
    output logic [`TAG_W-1:0]                  o_cmp_qj,
    output logic [`TAG_W-1:0]                  o_cmp_qk,
    output issue_pkg::cmp_op_e                 o_cmp_op,
    output logic [`TAG_W-1:0]                  o_cmp_dest,
    output logic [`XLEN-1:0]                   o_cmp_pc,
    output logic [`XLEN-1:0]                   o_cmp_imm,
    output logic                               o_cmp_br_pred,
    output logic                               o_rob_valid,
    output issue_pkg::rob_op_e                 o_rob_op,
    output logic [`REG_W-1:0]                  o_rob_dest
);
    import issue_pkg::*;

    logic             hit_j;
    logic             hit_k;
    logic [`XLEN-1:0] vj;
    logic [`XLEN-1:0] vk;
    logic [`TAG_W-1:0] qj;
    logic [`TAG_W-1:0] qk;

    // ==================================================
    // Forwarding and operand select
    // ==================================================
    assign hit_j = (i_reg_qj != '0) && i_rob_ready[i_reg_qj];
    assign hit_k = (i_reg_qk != '0) && i_rob_ready[i_reg_qk];

    always_comb begin
        vj = hit_j ? i_rob_vals[i_reg_qj] : i_reg_vj;
        qj = hit_j ? '0 : i_reg_qj;
        if (i_zero_rs1 || i_use_pc) begin
            vj = i_use_pc ? i_pc : '0;
            qj = '0;
        end
        // Branch compares rs1/rs2, its offset goes out separately
        vk = i_use_rs2 ? (hit_k ? i_rob_vals[i_reg_qk] : i_reg_vk) : i_imm;
        qk = (i_use_rs2 && !hit_k) ? i_reg_qk : '0;
    end

    // ==================================================
    // Dispatch registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
            o_rob_valid <= 1'b0;
        end else begin
            o_alu_valid <= i_accept && (i_unit == UNIT_ALU);
            o_cmp_valid <= i_accept && (i_unit == UNIT_CMP);
            o_rob_valid <= i_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (i_accept && i_unit == UNIT_ALU) begin
            o_alu_vj   <= vj;
            o_alu_vk   <= vk;
            o_alu_qj   <= qj;
            o_alu_qk   <= qk;
            o_alu_op   <= i_alu_op;
            o_alu_dest <= i_tag;
        end
        if (i_accept && i_unit == UNIT_CMP) begin
            o_cmp_is_br   <= i_is_br;
            o_cmp_vj      <= vj;
            o_cmp_vk      <= vk;
            o_cmp_qj      <= qj;
            o_cmp_qk      <= qk;
            o_cmp_op      <= i_cmp_op;
            o_cmp_dest    <= i_tag;
            o_cmp_pc      <= i_pc;
            o_cmp_imm     <= i_imm;
            o_cmp_br_pred <= i_br_pred;
        end
        if (i_accept) begin
            o_rob_op   <= i_is_br ? ROB_BR : ROB_REG;
            o_rob_dest <= i_rd; // raw rd field for branches
        end
    end

    a_one_station: assert property (@(posedge clk) disable iff (rst)
        !(o_alu_valid && o_cmp_valid));

endmodule

// ==== inst_decode.sv ====
/*
 * Pure combinational decode of the instruction at the queue head.
 * Only OP-IMM, OP, LUI, AUIPC and conditional branches are kept; anything
 * else, and branches with funct3 010/011, come out as unit none.
 */
`timescale 1ns/1ps
`include "issue_config.svh"

module inst_decode (
    input  logic [`XLEN-1:0]  i_inst,
    output issue_pkg::unit_e   o_unit,
    output issue_pkg::alu_op_e o_alu_op,
    output issue_pkg::cmp_op_e o_cmp_op,
    output logic               o_is_br,
    output logic               o_use_rs2,
    output logic               o_use_pc,
    output logic               o_zero_rs1,
    output logic               o_writes_rd,
    output logic [`XLEN-1:0]   o_imm,
    output logic [`REG_W-1:0]  o_rs1,
    output logic [`REG_W-1:0]  o_rs2,
    output logic [`REG_W-1:0]  o_rd
);
    import issue_pkg::*;

    inst_u            word;
    logic [2:0]       funct3;
    logic             f7_b5;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;

    assign word   = i_inst;
    assign funct3 = word.r_fmt.funct3;
    assign f7_b5  = word.r_fmt.funct7[5];

    assign o_rs1 = word.r_fmt.rs1;
    assign o_rs2 = word.r_fmt.rs2;
    assign o_rd  = word.r_fmt.rd;

    // ==================================================
    // Immediates
    // ==================================================
    assign imm_i = {{(`XLEN-12){word.i_fmt.imm[11]}}, word.i_fmt.imm};
    assign imm_b = {{(`XLEN-12){word.b_fmt.imm12}}, word.b_fmt.imm11,
                    word.b_fmt.imm10_5, word.b_fmt.imm4_1, 1'b0};
    assign imm_u = {word.u_fmt.imm, 12'h000};

    always_comb begin
        o_unit      = UNIT_NONE;
        o_alu_op    = ALU_ADD;
        o_cmp_op    = CMP_BEQ;
        o_is_br     = 1'b0;
        o_use_rs2   = 1'b0;
        o_use_pc    = 1'b0;
        o_zero_rs1  = 1'b0;
        o_writes_rd = 1'b0;
        o_imm       = '0;

        case (word.r_fmt.opcode)
            OP_IMM, OP_REG: begin
                o_writes_rd = 1'b1;
                o_use_rs2   = (word.r_fmt.opcode == OP_REG);
                o_imm       = imm_i;
                o_unit      = UNIT_ALU;
                case (funct3)
                    3'b000: o_alu_op = (o_use_rs2 && f7_b5) ? ALU_SUB : ALU_ADD;
                    3'b001: o_alu_op = ALU_SLL;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b101: o_alu_op = f7_b5 ? ALU_SRA : ALU_SRL;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    3'b010: begin
                        o_unit   = UNIT_CMP; // slt
                        o_cmp_op = CMP_BLT;
                    end
                    default: begin
                        o_unit   = UNIT_CMP; // sltu
                        o_cmp_op = CMP_BLTU;
                    end
                endcase
            end
            OP_LUI: begin
                o_unit      = UNIT_ALU;
                o_writes_rd = 1'b1;
                o_zero_rs1  = 1'b1; // 0 + imm
                o_imm       = imm_u;
            end
            OP_AUIPC: begin
                o_unit      = UNIT_ALU;
                o_writes_rd = 1'b1;
                o_use_pc    = 1'b1; // pc + imm
                o_imm       = imm_u;
            end
            OP_BR: begin
                o_is_br   = 1'b1;
                o_use_rs2 = 1'b1;
                o_imm     = imm_b;
                o_cmp_op  = cmp_op_e'(funct3);
                if (funct3[2:1] != 2'b01) begin
                    o_unit = UNIT_CMP;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== issue_config.svh ====
/*
 * Width and depth settings for the issue stage.
 * ROB_DEPTH must equal 2**TAG_W, since every tag indexes a ready bit.
 * Tag zero is reserved for "no producer" and "no free entry".
 */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// ==================================================
// Datapath
// ==================================================
`define XLEN 32
`define REG_W 5

// ==================================================
// ROB
// ==================================================
`define TAG_W 4
`define ROB_DEPTH 16

`endif

// ==== issue_ctrl.sv ====
/*
 * Accept and drop decision for the queue head, all combinational.
 * A dropped head shifts whatever the ROB and station state is.
 * clk and rst only drive the assertions.
 */
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  issue_pkg::unit_e  i_unit,
    input  logic              i_writes_rd,
    input  logic [`REG_W-1:0] i_rd,
    input  logic [`TAG_W-1:0] i_rob_free_tag,
    input  logic              i_alu_ready,
    input  logic              i_cmp_ready,
    output logic              o_shift,
    output logic              o_load_tag,
    output logic [`TAG_W-1:0] o_tag_out,
    output logic [`REG_W-1:0] o_rd_out,
    output logic              o_accept
);
    import issue_pkg::*;

    logic drop;
    logic unit_ready;

    // Unknown encodings and writes to x0 leave the queue without dispatch
    assign drop = (i_unit == UNIT_NONE) || (i_writes_rd && i_rd == '0);

    always_comb begin
        case (i_unit)
            UNIT_ALU: unit_ready = i_alu_ready;
            UNIT_CMP: unit_ready = i_cmp_ready;
            default:  unit_ready = 1'b0;
        endcase
    end

    assign o_accept   = i_valid && !drop && (i_rob_free_tag != '0) && unit_ready;
    assign o_shift    = o_accept || (i_valid && drop);
    assign o_load_tag = o_accept && i_writes_rd; // branches never rename
    assign o_tag_out  = o_load_tag ? i_rob_free_tag : '0;
    assign o_rd_out   = o_load_tag ? i_rd : '0;

    // ==================================================
    // Checks
    // ==================================================
    a_load_needs_shift: assert property (@(posedge clk) disable iff (rst)
        o_load_tag |-> o_shift);
    a_shift_needs_valid: assert property (@(posedge clk) disable iff (rst)
        o_shift |-> i_valid);

endmodule

// ==== issue_pkg.sv ====
/*
 * Shared types of the issue stage.
 * Struct fields follow the fixed RV32I layout and do not scale with XLEN.
 */
package issue_pkg;

    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_BR    = 7'b1100011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SLL = 3'b001,
        ALU_SRA = 3'b010,
        ALU_SUB = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_op_e;

    // Branch funct3, SLT and SLTU ride on blt and bltu
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

    typedef enum logic {
        ROB_REG = 1'b0,
        ROB_BR  = 1'b1
    } rob_op_e;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_CMP  = 2'd2
    } unit_e;

    // ==================================================
    // Instruction word views
    // ==================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

// ==== issue_unit.f ====
+incdir+.
issue_pkg.sv
inst_decode.sv
issue_ctrl.sv
dispatch_regs.sv
issue_unit.sv
tb_issue_unit.sv

// ==== issue_unit.sv ====
/*
 * Issue stage top. Shift and register-file tag load are same-cycle outputs,
 * station and ROB entries follow one cycle after the accept edge.
 * The ROB free tag must be zero when no entry is free.
 */
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_valid,
    input  logic [`XLEN-1:0]                   i_pc,
    input  logic [`XLEN-1:0]                   i_inst,
    input  logic                               i_br_pred,
    output logic                               o_shift,
    output logic [`REG_W-1:0]                  o_rs1,
    output logic [`REG_W-1:0]                  o_rs2,
    output logic                               o_load_tag,
    output logic [`TAG_W-1:0]                  o_tag_out,
    output logic [`REG_W-1:0]                  o_rd_out,
    input  logic [`TAG_W-1:0]                  i_reg_qj,
    input  logic [`TAG_W-1:0]                  i_reg_qk,
    input  logic [`XLEN-1:0]                   i_reg_vj,
    input  logic [`XLEN-1:0]                   i_reg_vk,
    input  logic [`TAG_W-1:0]                  i_rob_free_tag,
    input  logic [`ROB_DEPTH-1:0]              i_rob_ready,
    input  logic [`ROB_DEPTH-1:0][`XLEN-1:0]   i_rob_vals,
    output logic                               o_rob_valid,
    output issue_pkg::rob_op_e                 o_rob_op,
    output logic [`REG_W-1:0]                  o_rob_dest,
    input  logic                               i_alu_ready,
    output logic                               o_alu_valid,
    output logic [`XLEN-1:0]                   o_alu_vj,
    output logic [`XLEN-1:0]                   o_alu_vk,
    output logic [`TAG_W-1:0]                  o_alu_qj,
    output logic [`TAG_W-1:0]                  o_alu_qk,
    output issue_pkg::alu_op_e                 o_alu_op,
    output logic [`TAG_W-1:0]                  o_alu_dest,
    input  logic                               i_cmp_ready,
    output logic                               o_cmp_valid,
    output logic                               o_cmp_is_br,
    output logic [`XLEN-1:0]                   o_cmp_vj,
    output logic [`XLEN-1:0]                   o_cmp_vk,
    output logic [`TAG_W-1:0]                  o_cmp_qj,
    output logic [`TAG_W-1:0]                  o_cmp_qk,
    output issue_pkg::cmp_op_e                 o_cmp_op,
    output logic [`TAG_W-1:0]                  o_cmp_dest,
    output logic [`XLEN-1:0]                   o_cmp_pc,
    output logic [`XLEN-1:0]                   o_cmp_imm,
    output logic                               o_cmp_br_pred
);
    import issue_pkg::*;

    unit_e             unit;
    alu_op_e           alu_op;
    cmp_op_e           cmp_op;
    logic              is_br;
    logic              use_rs2;
    logic              use_pc;
    logic              zero_rs1;
    logic              writes_rd;
    logic [`XLEN-1:0]  imm;
    logic [`REG_W-1:0] rd;
    logic              accept;

    inst_decode decode_i (
        .i_inst(i_inst), .o_unit(unit), .o_alu_op(alu_op), .o_cmp_op(cmp_op),
        .o_is_br(is_br), .o_use_rs2(use_rs2), .o_use_pc(use_pc),
        .o_zero_rs1(zero_rs1), .o_writes_rd(writes_rd), .o_imm(imm),
        .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(rd)
    );

    issue_ctrl ctrl_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_unit(unit),
        .i_writes_rd(writes_rd), .i_rd(rd), .i_rob_free_tag(i_rob_free_tag),
        .i_alu_ready(i_alu_ready), .i_cmp_ready(i_cmp_ready),
        .o_shift(o_shift), .o_load_tag(o_load_tag), .o_tag_out(o_tag_out),
        .o_rd_out(o_rd_out), .o_accept(accept)
    );

    dispatch_regs dispatch_i (
        .clk(clk), .rst(rst), .i_accept(accept), .i_unit(unit),
        .i_alu_op(alu_op), .i_cmp_op(cmp_op), .i_is_br(is_br),
        .i_use_rs2(use_rs2), .i_use_pc(use_pc), .i_zero_rs1(zero_rs1),
        .i_imm(imm), .i_pc(i_pc), .i_br_pred(i_br_pred), .i_rd(rd),
        .i_tag(i_rob_free_tag),
        .i_reg_qj(i_reg_qj), .i_reg_qk(i_reg_qk),
        .i_reg_vj(i_reg_vj), .i_reg_vk(i_reg_vk),
        .i_rob_ready(i_rob_ready), .i_rob_vals(i_rob_vals),
        .o_alu_valid(o_alu_valid), .o_alu_vj(o_alu_vj), .o_alu_vk(o_alu_vk),
        .o_alu_qj(o_alu_qj), .o_alu_qk(o_alu_qk), .o_alu_op(o_alu_op),
        .o_alu_dest(o_alu_dest),
        .o_cmp_valid(o_cmp_valid), .o_cmp_is_br(o_cmp_is_br),
        .o_cmp_vj(o_cmp_vj), .o_cmp_vk(o_cmp_vk),
        .o_cmp_qj(o_cmp_qj), .o_cmp_qk(o_cmp_qk), .o_cmp_op(o_cmp_op),
        .o_cmp_dest(o_cmp_dest), .o_cmp_pc(o_cmp_pc), .o_cmp_imm(o_cmp_imm),
        .o_cmp_br_pred(o_cmp_br_pred),
        .o_rob_valid(o_rob_valid), .o_rob_op(o_rob_op), .o_rob_dest(o_rob_dest)
    );

endmodule

// ==== tb_issue_unit.sv ====
/*
 * Random testbench for the issue stage, checked against a reference model.
 * Inputs change on falling edges; same-cycle outputs are checked 1 ns later,
 * dispatch outputs at the following falling edge.
 */
`timescale 1ns/1ps
`include "issue_config.svh"

module tb_issue_unit;
    import issue_pkg::*;

    localparam int N_CYCLES   = 2000;
    localparam int RST_CYCLES = 5;
    localparam int MAX_CYCLES = N_CYCLES + RST_CYCLES + 50;

    logic clk = 1'b0;
    logic rst;
    logic i_valid, i_br_pred, i_alu_ready, i_cmp_ready;
    logic [`XLEN-1:0] i_pc, i_inst, i_reg_vj, i_reg_vk;
    logic [`TAG_W-1:0] i_reg_qj, i_reg_qk, i_rob_free_tag;
    logic [`ROB_DEPTH-1:0] i_rob_ready;
    logic [`ROB_DEPTH-1:0][`XLEN-1:0] i_rob_vals;
    logic o_shift, o_load_tag, o_rob_valid, o_alu_valid, o_cmp_valid;
    logic o_cmp_is_br, o_cmp_br_pred;
    logic [`REG_W-1:0] o_rs1, o_rs2, o_rd_out, o_rob_dest;
    logic [`TAG_W-1:0] o_tag_out, o_alu_qj, o_alu_qk, o_alu_dest;
    logic [`TAG_W-1:0] o_cmp_qj, o_cmp_qk, o_cmp_dest;
    logic [`XLEN-1:0] o_alu_vj, o_alu_vk, o_cmp_vj, o_cmp_vk, o_cmp_pc, o_cmp_imm;
    rob_op_e o_rob_op;
    alu_op_e o_alu_op;
    cmp_op_e o_cmp_op;

    logic [31:0] rng;
    int errors = 0;
    int cycles = 0;

    // Model results for the head in the current cycle
    logic exp_accept, exp_shift, exp_load, exp_is_br, exp_pred;
    logic [`TAG_W-1:0] exp_tag_out, exp_tag, exp_qj, exp_qk;
    logic [`REG_W-1:0] exp_rd_out, exp_rob_dest;
    logic [`XLEN-1:0] exp_vj, exp_vk, exp_imm, exp_pc;
    unit_e exp_unit;
    alu_op_e exp_alu_op;
    cmp_op_e exp_cmp_op;
    rob_op_e exp_rob_op;

    issue_unit dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic b30,
                                           input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && b30) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b100:  return ALU_XOR;
            3'b101:  return b30 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] word;
        int k;
        r = next_random();
        word = next_random();
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: word[6:0] = OP_IMM;
            4'd4, 4'd5, 4'd6: begin
                word[6:0] = OP_REG;
                word[31:25] = {1'b0, r[4], 5'b00000};
            end
            4'd7: word[6:0] = OP_LUI;
            4'd8: word[6:0] = OP_AUIPC;
            4'd9, 4'd10, 4'd11: word[6:0] = OP_BR;
            4'd12: word[6:0] = OP_LOAD;
            4'd13: word[6:0] = OP_STORE;
            4'd14: word[6:0] = OP_JAL;
            default: ; // fully random word
        endcase
        if (r[7:5] == 3'b000) begin
            word[11:7] = 5'b00000; // extra rd-zero cases
        end
        i_inst = word;
        i_valid = (r[10:8] != 3'b000);
        i_alu_ready = (r[12:11] != 2'b00);
        i_cmp_ready = (r[14:13] != 2'b00);
        i_rob_free_tag = (r[17:15] == 3'b000) ? '0 : r[21:18];
        i_br_pred = r[22];
        i_reg_qj = r[26:23];
        i_reg_qk = r[30:27];
        word = next_random();
        i_pc = {word[31:2], 2'b00};
        i_reg_vj = next_random();
        i_reg_vk = next_random();
        word = next_random();
        i_rob_ready = word[`ROB_DEPTH-1:0];
        for (k = 0; k < `ROB_DEPTH; k++) begin
            i_rob_vals[k] = next_random();
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    task automatic predict();
        logic [6:0] opc;
        logic [2:0] f3;
        logic [4:0] rd;
        logic writes, use_rs2, fwd_j, fwd_k, ready, drop;
        opc = i_inst[6:0];
        f3 = i_inst[14:12];
        rd = i_inst[11:7];
        writes = 1'b0;
        use_rs2 = 1'b0;
        exp_unit = UNIT_NONE;
        exp_alu_op = ALU_ADD;
        exp_cmp_op = CMP_BEQ;
        exp_is_br = 1'b0;
        exp_imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
        fwd_j = (i_reg_qj != '0) && i_rob_ready[i_reg_qj];
        fwd_k = (i_reg_qk != '0) && i_rob_ready[i_reg_qk];
        exp_vj = fwd_j ? i_rob_vals[i_reg_qj] : i_reg_vj;
        exp_qj = fwd_j ? '0 : i_reg_qj;
        exp_vk = fwd_k ? i_rob_vals[i_reg_qk] : i_reg_vk;
        exp_qk = fwd_k ? '0 : i_reg_qk;
        case (opc)
            7'b0010011, 7'b0110011: begin
                writes = 1'b1;
                use_rs2 = opc[5];
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    exp_unit = UNIT_CMP;
                    exp_cmp_op = (f3 == 3'b010) ? CMP_BLT : CMP_BLTU;
                end else begin
                    exp_unit = UNIT_ALU;
                    exp_alu_op = alu_op_for(f3, i_inst[30], opc[5]);
                end
            end
            7'b0110111, 7'b0010111: begin
                writes = 1'b1;
                exp_unit = UNIT_ALU;
                exp_imm = {i_inst[31:12], 12'h000};
                exp_vj = opc[5] ? '0 : i_pc; // LUI adds to zero, AUIPC to pc
                exp_qj = '0;
            end
            7'b1100011: begin
                exp_is_br = 1'b1;
                use_rs2 = 1'b1;
                exp_imm = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                           i_inst[11:8], 1'b0};
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    exp_unit = UNIT_CMP;
                    exp_cmp_op = cmp_op_e'(f3);
                end
            end
            default: ;
        endcase
        if (!use_rs2) begin
            exp_vk = exp_imm;
            exp_qk = '0;
        end
        ready = (exp_unit == UNIT_ALU) ? i_alu_ready :
                (exp_unit == UNIT_CMP) ? i_cmp_ready : 1'b0;
        drop = (exp_unit == UNIT_NONE) || (writes && rd == 5'd0);
        exp_accept = i_valid && !drop && (i_rob_free_tag != '0) && ready;
        exp_shift = exp_accept || (i_valid && drop);
        exp_load = exp_accept && writes;
        exp_tag_out = exp_load ? i_rob_free_tag : '0;
        exp_rd_out = exp_load ? rd : '0;
        exp_rob_op = exp_is_br ? ROB_BR : ROB_REG;
        exp_rob_dest = rd;
        exp_tag = i_rob_free_tag;
        exp_pc = i_pc;
        exp_pred = i_br_pred;
    endtask

    // ==================================================
    // Checks
    // ==================================================
    task automatic report_mismatch(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic check_ctrl(input logic shift, input logic load,
                              input logic [`TAG_W-1:0] tag, input logic [`REG_W-1:0] rd);
        if (o_shift !== shift || o_load_tag !== load || o_tag_out !== tag ||
            o_rd_out !== rd || o_rs1 !== i_inst[19:15] || o_rs2 !== i_inst[24:20]) begin
            report_mismatch($sformatf("ctrl shift %b/%b load %b/%b tag %0d/%0d rd %0d/%0d",
                            o_shift, shift, o_load_tag, load, o_tag_out, tag, o_rd_out, rd));
        end
    endtask

    task automatic check_alu(input logic valid, input alu_op_e op,
                             input logic [`XLEN-1:0] vj, vk,
                             input logic [`TAG_W-1:0] qj, qk, dest);
        if (o_alu_valid !== valid) begin
            report_mismatch($sformatf("alu valid %b, expected %b", o_alu_valid, valid));
        end else if (valid && (o_alu_op !== op || o_alu_vj !== vj || o_alu_vk !== vk ||
                     o_alu_qj !== qj || o_alu_qk !== qk || o_alu_dest !== dest)) begin
            report_mismatch($sformatf("alu %s vj %h vk %h qj %0d qk %0d dest %0d, expected %s %h %h %0d %0d %0d",
                            o_alu_op.name(), o_alu_vj, o_alu_vk, o_alu_qj, o_alu_qk,
                            o_alu_dest, op.name(), vj, vk, qj, qk, dest));
        end
    endtask

    task automatic check_cmp(input logic valid, input logic is_br, input cmp_op_e op,
                             input logic [`XLEN-1:0] vj, vk, pc, imm,
                             input logic [`TAG_W-1:0] qj, qk, dest, input logic pred);
        if (o_cmp_valid !== valid) begin
            report_mismatch($sformatf("cmp valid %b, expected %b", o_cmp_valid, valid));
        end else if (valid && (o_cmp_is_br !== is_br || o_cmp_op !== op ||
                     o_cmp_vj !== vj || o_cmp_vk !== vk || o_cmp_qj !== qj ||
                     o_cmp_qk !== qk || o_cmp_dest !== dest || o_cmp_pc !== pc ||
                     o_cmp_imm !== imm || o_cmp_br_pred !== pred)) begin
            report_mismatch($sformatf("cmp %s br %b vj %h vk %h imm %h, expected %s %b %h %h %h",
                            o_cmp_op.name(), o_cmp_is_br, o_cmp_vj, o_cmp_vk, o_cmp_imm,
                            op.name(), is_br, vj, vk, imm));
        end
    endtask

    task automatic check_rob(input logic valid, input rob_op_e op,
                             input logic [`REG_W-1:0] dest);
        if (o_rob_valid !== valid) begin
            report_mismatch($sformatf("rob valid %b, expected %b", o_rob_valid, valid));
        end else if (valid && (o_rob_op !== op || o_rob_dest !== dest)) begin
            report_mismatch($sformatf("rob %s dest %0d, expected %s %0d",
                            o_rob_op.name(), o_rob_dest, op.name(), dest));
        end
    endtask

    // Outputs registered from the previous cycle's head
    task automatic check_dispatch();
        check_alu(exp_accept && exp_unit == UNIT_ALU, exp_alu_op, exp_vj, exp_vk,
                  exp_qj, exp_qk, exp_tag);
        check_cmp(exp_accept && exp_unit == UNIT_CMP, exp_is_br, exp_cmp_op, exp_vj,
                  exp_vk, exp_pc, exp_imm, exp_qj, exp_qk, exp_tag, exp_pred);
        check_rob(exp_accept, exp_rob_op, exp_rob_dest);
    endtask

    initial begin
        rng = 32'he86bfd33;
        rst = 1'b1;
        i_valid = 1'b0;
        i_pc = '0;
        i_inst = '0;
        i_br_pred = 1'b0;
        i_alu_ready = 1'b0;
        i_cmp_ready = 1'b0;
        i_reg_qj = '0;
        i_reg_qk = '0;
        i_reg_vj = '0;
        i_reg_vk = '0;
        i_rob_free_tag = '0;
        i_rob_ready = '0;
        i_rob_vals = '0;
        exp_accept = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        check_dispatch(); // all valids low out of reset
        rst = 1'b0;
        for (int n = 0; n < N_CYCLES; n++) begin
            drive_random();
            #1;
            predict();
            check_ctrl(exp_shift, exp_load, exp_tag_out, exp_rd_out);
            @(negedge clk);
            check_dispatch();
        end
        i_valid = 1'b0;
        $display("Done: %0d cycles, %0d errors", N_CYCLES, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
